// File: Bender.yml
package:
  name: soc_mem

sources:
  - files:
      - logic/soc_mem_pkg.sv
      - logic/uart_prog_loader.sv
      - logic/ram_port_arbiter.sv
      - logic/byte_write_ram.sv
      - logic/iomem_decoder.sv
      - logic/soc_mem_top.sv
  - target: test
    files:
      - verif/soc_mem_asserts.sv
      - verif/soc_mem_tb.sv

// File: logic/byte_write_ram.sv
`timescale 1ns/1ps
`default_nettype none

module byte_write_ram import soc_mem_pkg::*; (
  input  logic              clk_i,
  input  logic              en_i,
  input  logic [3:0]        we_i,
  input  logic [RAM_AW-1:0] addr_i,
  input  logic [31:0]       wdata_i,
  output logic [31:0]       rdata_o
);

  // Four byte columns per word
  logic [3:0][7:0] mem_q [RAM_WORDS];

  always_ff @(posedge clk_i) begin
    if (en_i) begin
      for (int lane = 0; lane < 4; lane++) begin
        if (we_i[lane]) begin
          mem_q[addr_i][lane] <= wdata_i[lane*8 +: 8];
        end
      end
    end
  end

  // Registered read returns the old word during a write
  always_ff @(posedge clk_i) begin
    if (en_i) begin
      rdata_o <= mem_q[addr_i];
    end
  end

endmodule

`default_nettype wire

// File: logic/iomem_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module iomem_decoder import soc_mem_pkg::*; (
  input  logic        clk_i,
  input  logic        rst_n,
  input  logic        mem_valid_i,
  input  logic [3:0]  mem_wstrb_i,
  input  logic [31:0] mem_addr_i,
  output logic        mem_ready_o,
  output logic [31:0] mem_rdata_o,
  input  logic [31:0] ram_rdata_i,
  input  logic        cpu_gnt_i,
  output logic        cpu_ram_req_o,
  output logic        cpu_done_o
);

  bus_target_e          tgt;
  logic                 is_read;
  logic [LAT_CNT_W-1:0] lat_cnt_q;
  logic                 ram_ready_q;
  logic [63:0]          timer_q;

  ////////////////////////////////////////
  // Address decode
  ////////////////////////////////////////
  always_comb begin
    if ((mem_addr_i & ~RAM_MASK_ADDR) == RAM_BASE_ADDR) begin
      tgt = TGT_RAM;
    end else if (mem_addr_i == TIMER_LO_ADDR) begin
      tgt = TGT_TIMER_LO;
    end else if (mem_addr_i == TIMER_HI_ADDR) begin
      tgt = TGT_TIMER_HI;
    end else begin
      tgt = TGT_NONE;
    end
  end

  assign is_read = (mem_wstrb_i == 4'h0);

  // Request drops in the ready cycle
  assign cpu_ram_req_o = mem_valid_i && (tgt == TGT_RAM) && !ram_ready_q;
  assign cpu_done_o    = ram_ready_q;

  ////////////////////////////////////////
  // RAM latency counter
  ////////////////////////////////////////
  always_ff @(posedge clk_i) begin
    if (!rst_n) begin
      lat_cnt_q   <= '0;
      ram_ready_q <= 1'b0;
    end else begin
      ram_ready_q <= 1'b0;
      if (cpu_gnt_i && cpu_ram_req_o) begin
        if (lat_cnt_q == LAT_CNT_W'(RAM_LATENCY)) begin
          ram_ready_q <= 1'b1;
          lat_cnt_q   <= '0;
        end else begin
          lat_cnt_q <= lat_cnt_q + 1'b1;
        end
      end
    end
  end

  // Free-running cycle timer
  always_ff @(posedge clk_i) begin
    if (!rst_n) begin
      timer_q <= 64'd0;
    end else begin
      timer_q <= timer_q + 64'd1;
    end
  end

  ////////////////////////////////////////
  // Response
  ////////////////////////////////////////
  // Timer and holes answer without wait states
  assign mem_ready_o = ram_ready_q || (mem_valid_i && tgt != TGT_RAM);

  always_comb begin
    mem_rdata_o = 32'd0;
    if (is_read) begin
      case (tgt)
        TGT_RAM:      mem_rdata_o = ram_rdata_i;
        TGT_TIMER_LO: mem_rdata_o = timer_q[31:0];
        TGT_TIMER_HI: mem_rdata_o = timer_q[63:32];
        default:      mem_rdata_o = 32'd0;
      endcase
    end
  end

endmodule

`default_nettype wire

// File: logic/ram_port_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module ram_port_arbiter import soc_mem_pkg::*; (
  input  logic              clk_i,
  input  logic              rst_n,
  input  logic              ld_req_i,
  input  logic [RAM_AW-1:0] ld_addr_i,
  input  logic [31:0]       ld_wdata_i,
  output logic              ld_gnt_o,
  input  logic              cpu_ram_req_i,
  input  logic              cpu_done_i,
  output logic              cpu_gnt_o,
  input  logic [3:0]        cpu_wstrb_i,
  input  logic [31:0]       cpu_addr_i,
  input  logic [31:0]       cpu_wdata_i,
  output logic              ram_en_o,
  output logic [3:0]        ram_we_o,
  output logic [RAM_AW-1:0] ram_addr_o,
  output logic [31:0]       ram_wdata_o
);

  logic cpu_lock_q;
  logic cpu_first;

  // Loader first, unless a CPU access already owns the port
  assign ld_gnt_o  = ld_req_i && !cpu_lock_q;
  assign cpu_gnt_o = cpu_lock_q || (cpu_ram_req_i && !ld_req_i);
  assign cpu_first = cpu_gnt_o && !cpu_lock_q;

  always_ff @(posedge clk_i) begin
    if (!rst_n) begin
      cpu_lock_q <= 1'b0;
    end else if (cpu_done_i) begin
      cpu_lock_q <= 1'b0;
    end else if (cpu_gnt_o) begin
      cpu_lock_q <= 1'b1;
    end
  end

  ////////////////////////////////////////
  // RAM port mux
  ////////////////////////////////////////
  assign ram_en_o    = ld_gnt_o || cpu_gnt_o;
  assign ram_addr_o  = ld_gnt_o ? ld_addr_i : cpu_addr_i[RAM_AW+1:2];
  assign ram_wdata_o = ld_gnt_o ? ld_wdata_i : cpu_wdata_i;

  // CPU writes only once while reads repeat until ready
  assign ram_we_o = ld_gnt_o  ? 4'hF :
                    cpu_first ? cpu_wstrb_i : 4'h0;

endmodule

`default_nettype wire

// File: logic/soc_mem_pkg.sv
`default_nettype none

package soc_mem_pkg;

  ////////////////////////////////////////
  // Address map
  ////////////////////////////////////////
  localparam logic [31:0] RAM_BASE_ADDR = 32'h4000_0000;
  localparam logic [31:0] RAM_MASK_ADDR = 32'h000F_FFFF;
  localparam logic [31:0] TIMER_LO_ADDR = 32'h3000_0000;
  localparam logic [31:0] TIMER_HI_ADDR = 32'h3000_0004;

  // Main memory geometry
  localparam int RAM_WORDS = 1024;
  localparam int RAM_AW    = 10;

  // Cycles from the first granted edge to ready
  localparam int RAM_LATENCY = 4;
  localparam int LAT_CNT_W   = $clog2(RAM_LATENCY + 1);

  // Program loader UART
  localparam int          CLKS_PER_BIT = 8;
  localparam int          CLK_CNT_W    = $clog2(CLKS_PER_BIT);
  localparam logic [7:0]  PROG_CMD     = 8'hA5;

  ////////////////////////////////////////
  // Enumerations
  ////////////////////////////////////////
  typedef enum logic [1:0] {
    TGT_RAM,
    TGT_TIMER_LO,
    TGT_TIMER_HI,
    TGT_NONE
  } bus_target_e;

  typedef enum logic [2:0] {
    LD_IDLE,
    LD_CNT_LO,
    LD_CNT_HI,
    LD_DATA,
    LD_WRITE
  } loader_state_e;

endpackage

`default_nettype wire

// File: logic/soc_mem_top.sv
`timescale 1ns/1ps
`default_nettype none

module soc_mem_top import soc_mem_pkg::*; (
  input  logic        clk_i,
  input  logic        rst_n,
  input  logic        mem_valid_i,
  output logic        mem_ready_o,
  input  logic [3:0]  mem_wstrb_i,
  input  logic [31:0] mem_addr_i,
  input  logic [31:0] mem_wdata_i,
  output logic [31:0] mem_rdata_o,
  input  logic        prog_rx_i,
  output logic        prog_mode_o,
  output logic        sys_rst_n_o
);

  logic              cpu_ram_req;
  logic              cpu_gnt;
  logic              cpu_done;
  logic              ld_req;
  logic              ld_gnt;
  logic [RAM_AW-1:0] ld_addr;
  logic [31:0]       ld_wdata;
  logic              ram_en;
  logic [3:0]        ram_we;
  logic [RAM_AW-1:0] ram_addr;
  logic [31:0]       ram_wdata;
  logic [31:0]       ram_rdata;

  // Processor stays in reset while a program loads
  assign sys_rst_n_o = rst_n && !prog_mode_o;

  iomem_decoder u_decoder (
    .clk_i         (clk_i),
    .rst_n         (rst_n),
    .mem_valid_i   (mem_valid_i),
    .mem_wstrb_i   (mem_wstrb_i),
    .mem_addr_i    (mem_addr_i),
    .mem_ready_o   (mem_ready_o),
    .mem_rdata_o   (mem_rdata_o),
    .ram_rdata_i   (ram_rdata),
    .cpu_gnt_i     (cpu_gnt),
    .cpu_ram_req_o (cpu_ram_req),
    .cpu_done_o    (cpu_done)
  );

  ram_port_arbiter u_arbiter (
    .clk_i         (clk_i),
    .rst_n         (rst_n),
    .ld_req_i      (ld_req),
    .ld_addr_i     (ld_addr),
    .ld_wdata_i    (ld_wdata),
    .ld_gnt_o      (ld_gnt),
    .cpu_ram_req_i (cpu_ram_req),
    .cpu_done_i    (cpu_done),
    .cpu_gnt_o     (cpu_gnt),
    .cpu_wstrb_i   (mem_wstrb_i),
    .cpu_addr_i    (mem_addr_i),
    .cpu_wdata_i   (mem_wdata_i),
    .ram_en_o      (ram_en),
    .ram_we_o      (ram_we),
    .ram_addr_o    (ram_addr),
    .ram_wdata_o   (ram_wdata)
  );

  byte_write_ram u_ram (
    .clk_i   (clk_i),
    .en_i    (ram_en),
    .we_i    (ram_we),
    .addr_i  (ram_addr),
    .wdata_i (ram_wdata),
    .rdata_o (ram_rdata)
  );

  uart_prog_loader u_loader (
    .clk_i       (clk_i),
    .rst_n       (rst_n),
    .rx_i        (prog_rx_i),
    .ld_gnt_i    (ld_gnt),
    .ld_req_o    (ld_req),
    .ld_addr_o   (ld_addr),
    .ld_wdata_o  (ld_wdata),
    .prog_mode_o (prog_mode_o)
  );

endmodule

`default_nettype wire

// File: logic/uart_prog_loader.sv
`timescale 1ns/1ps
`default_nettype none

module uart_prog_loader import soc_mem_pkg::*; (
  input  logic              clk_i,
  input  logic              rst_n,
  input  logic              rx_i,
  input  logic              ld_gnt_i,
  output logic              ld_req_o,
  output logic [RAM_AW-1:0] ld_addr_o,
  output logic [31:0]       ld_wdata_o,
  output logic              prog_mode_o
);

  logic                 rx_meta_q;
  logic                 rx_sync_q;
  logic                 rx_busy_q;
  logic [CLK_CNT_W-1:0] rx_clk_q;
  logic [3:0]           rx_bit_q;
  logic [7:0]           rx_shift_q;
  logic                 rx_tick;
  logic                 rx_done;

  loader_state_e     state_q;
  logic [15:0]       words_left_q;
  logic [1:0]        byte_idx_q;
  logic [RAM_AW-1:0] addr_q;
  logic [31:0]       word_q;

  ////////////////////////////////////////
  // UART receiver
  ////////////////////////////////////////
  always_ff @(posedge clk_i) begin
    if (!rst_n) begin
      rx_meta_q <= 1'b1;
      rx_sync_q <= 1'b1;
    end else begin
      rx_meta_q <= rx_i;
      rx_sync_q <= rx_meta_q;
    end
  end

  // Mid-bit sample point
  assign rx_tick = rx_busy_q && (rx_clk_q == CLK_CNT_W'(CLKS_PER_BIT - 1));
  // Frame complete with a valid stop bit
  assign rx_done = rx_tick && (rx_bit_q == 4'd9) && rx_sync_q;

  always_ff @(posedge clk_i) begin
    if (!rst_n) begin
      rx_busy_q <= 1'b0;
      rx_clk_q  <= '0;
      rx_bit_q  <= '0;
    end else if (!rx_busy_q) begin
      if (!rx_sync_q) begin
        // Start half a bit early so every wrap lands mid-bit
        rx_busy_q <= 1'b1;
        rx_clk_q  <= CLK_CNT_W'(CLKS_PER_BIT / 2);
        rx_bit_q  <= '0;
      end
    end else if (rx_tick) begin
      rx_clk_q <= '0;
      if (rx_bit_q == 4'd0 && rx_sync_q) begin
        // False start
        rx_busy_q <= 1'b0;
      end else if (rx_bit_q == 4'd9) begin
        rx_busy_q <= 1'b0;
      end else begin
        rx_bit_q <= rx_bit_q + 4'd1;
      end
    end else begin
      rx_clk_q <= rx_clk_q + 1'b1;
    end
  end

  // LSB arrives first
  always_ff @(posedge clk_i) begin
    if (rx_tick && rx_bit_q != 4'd0 && rx_bit_q != 4'd9) begin
      rx_shift_q <= {rx_sync_q, rx_shift_q[7:1]};
    end
  end

  ////////////////////////////////////////
  // Load command parser
  ////////////////////////////////////////
  always_ff @(posedge clk_i) begin
    if (!rst_n) begin
      state_q      <= LD_IDLE;
      words_left_q <= '0;
      byte_idx_q   <= '0;
      addr_q       <= '0;
    end else begin
      case (state_q)
        LD_IDLE: begin
          if (rx_done && rx_shift_q == PROG_CMD) begin
            state_q <= LD_CNT_LO;
          end
        end
        LD_CNT_LO: begin
          if (rx_done) begin
            words_left_q[7:0] <= rx_shift_q;
            state_q           <= LD_CNT_HI;
          end
        end
        LD_CNT_HI: begin
          if (rx_done) begin
            words_left_q[15:8] <= rx_shift_q;
            byte_idx_q         <= '0;
            addr_q             <= '0;
            // Empty load finishes here
            if ({rx_shift_q, words_left_q[7:0]} == 16'd0) begin
              state_q <= LD_IDLE;
            end else begin
              state_q <= LD_DATA;
            end
          end
        end
        LD_DATA: begin
          if (rx_done) begin
            byte_idx_q <= byte_idx_q + 2'd1;
            if (byte_idx_q == 2'd3) begin
              state_q <= LD_WRITE;
            end
          end
        end
        LD_WRITE: begin
          if (ld_gnt_i) begin
            addr_q       <= addr_q + 1'b1;
            words_left_q <= words_left_q - 16'd1;
            if (words_left_q == 16'd1) begin
              state_q <= LD_IDLE;
            end else begin
              state_q <= LD_DATA;
            end
          end
        end
        default: state_q <= LD_IDLE;
      endcase
    end
  end

  // Word assembly
  always_ff @(posedge clk_i) begin
    if (state_q == LD_DATA && rx_done) begin
      word_q <= {rx_shift_q, word_q[31:8]};
    end
  end

  assign ld_req_o    = (state_q == LD_WRITE);
  assign ld_addr_o   = addr_q;
  assign ld_wdata_o  = word_q;
  assign prog_mode_o = (state_q != LD_IDLE);

endmodule

`default_nettype wire

// File: verif/soc_mem_asserts.sv
`timescale 1ns/1ps
`default_nettype none

module soc_mem_asserts (
  input logic clk_i,
  input logic rst_n,
  input logic ld_gnt_i,
  input logic cpu_gnt_i,
  input logic cpu_done_i,
  input logic mem_valid_i,
  input logic mem_ready_i
);

  // At most one master owns the RAM port
  grant_onehot: assert property (@(posedge clk_i) disable iff (!rst_n)
    $onehot0({ld_gnt_i, cpu_gnt_i})) else $error("RAM grants overlap");

  // A granted CPU access keeps the port until cpu_done
  no_ld_gnt_locked: assert property (@(posedge clk_i) disable iff (!rst_n)
    cpu_gnt_i && !cpu_done_i |=> !ld_gnt_i) else $error("Loader granted during a CPU lock");

  ready_needs_valid: assert property (@(posedge clk_i) disable iff (!rst_n)
    mem_ready_i |-> mem_valid_i) else $error("Ready without a valid request");

  done_pulse: assert property (@(posedge clk_i) disable iff (!rst_n)
    cpu_done_i |=> !cpu_done_i) else $error("cpu_done held longer than a cycle");

endmodule

bind ram_port_arbiter soc_mem_asserts u_arb_asserts (
  .clk_i       (clk_i),
  .rst_n       (rst_n),
  .ld_gnt_i    (ld_gnt_o),
  .cpu_gnt_i   (cpu_gnt_o),
  .cpu_done_i  (cpu_done_i),
  .mem_valid_i (1'b0),
  .mem_ready_i (1'b0)
);

bind iomem_decoder soc_mem_asserts u_dec_asserts (
  .clk_i       (clk_i),
  .rst_n       (rst_n),
  .ld_gnt_i    (1'b0),
  .cpu_gnt_i   (1'b0),
  .cpu_done_i  (cpu_done_o),
  .mem_valid_i (mem_valid_i),
  .mem_ready_i (mem_ready_o)
);

`default_nettype wire

// File: verif/soc_mem_tb.sv
`timescale 1ns/1ps
`default_nettype none

module soc_mem_tb import soc_mem_pkg::*; ();

  logic        clk_i;
  logic        rst_n;
  logic        mem_valid_i;
  logic        mem_ready_o;
  logic [3:0]  mem_wstrb_i;
  logic [31:0] mem_addr_i;
  logic [31:0] mem_wdata_i;
  logic [31:0] mem_rdata_o;
  logic        prog_rx_i;
  logic        prog_mode_o;
  logic        sys_rst_n_o;

  string       v_op[$];
  string       v_name[$];
  logic [31:0] v_addr[$];
  logic [3:0]  v_strb[$];
  logic [31:0] v_data[$];
  logic [31:0] v_exp[$];

  int          errors;
  int          limit_cycles;
  logic [15:0] lfsr;
  logic        prog_seen;

  soc_mem_top dut0 (
    .clk_i       (clk_i),
    .rst_n       (rst_n),
    .mem_valid_i (mem_valid_i),
    .mem_ready_o (mem_ready_o),
    .mem_wstrb_i (mem_wstrb_i),
    .mem_addr_i  (mem_addr_i),
    .mem_wdata_i (mem_wdata_i),
    .mem_rdata_o (mem_rdata_o),
    .prog_rx_i   (prog_rx_i),
    .prog_mode_o (prog_mode_o),
    .sys_rst_n_o (sys_rst_n_o)
  );

  initial clk_i = 1'b0;
  always #4 clk_i = ~clk_i;

  ////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
  endfunction

  // RAM window spans the base address up to base plus mask
  function automatic logic in_ram_window(input logic [31:0] addr);
    return addr >= RAM_BASE_ADDR && addr <= (RAM_BASE_ADDR | RAM_MASK_ADDR);
  endfunction

  // Two LFSR bits give 0 to 3 idle cycles
  task automatic idle_gap();
    int n;
    lfsr = lfsr_next(lfsr);
    n = lfsr[0];
    lfsr = lfsr_next(lfsr);
    n = n * 2 + lfsr[0];
    repeat (n) @(negedge clk_i);
  endtask

  // Starts and ends on a falling edge; waits counts falling edges to ready
  task automatic bus_access(input logic [31:0] addr, input logic [3:0] strb,
                            input logic [31:0] wdata, output logic [31:0] rdata,
                            output int waits, output int gnt_wait);
    mem_valid_i = 1'b1;
    mem_addr_i  = addr;
    mem_wstrb_i = strb;
    mem_wdata_i = wdata;
    waits       = 0;
    gnt_wait    = -1;
    #2;
    while (!mem_ready_o && waits < 100) begin
      if (gnt_wait < 0 && dut0.cpu_gnt) gnt_wait = waits;
      @(negedge clk_i);
      #2;
      waits++;
    end
    if (gnt_wait < 0) gnt_wait = waits;
    rdata = mem_rdata_o;
    assert (mem_ready_o) else begin
      errors++;
      $display("Bus access to %h never got a ready", addr);
    end
    @(negedge clk_i);
    mem_valid_i = 1'b0;
    mem_wstrb_i = 4'h0;
  endtask

  task automatic check_latency(input string name, input logic [31:0] addr, input int waits);
    int exp_waits;
    // Ready shows up after RAM_LATENCY edges past the first granted edge
    exp_waits = in_ram_window(addr) ? RAM_LATENCY + 1 : 0;
    assert (waits == exp_waits) else begin
      errors++;
      $display("Error %s latency: expected %0d, actual %0d", name, exp_waits, waits);
    end
  endtask

  task automatic send_byte(input logic [7:0] b);
    logic [9:0] frame;
    frame = {1'b1, b, 1'b0};
    for (int k = 0; k < 10; k++) begin
      prog_rx_i = frame[k];
      repeat (CLKS_PER_BIT) @(negedge clk_i);
    end
  endtask

  task automatic send_load(input logic send_junk, input logic [7:0] junk,
                           input int first, input int count);
    prog_seen = 1'b0;
    if (send_junk) begin
      send_byte(junk);
      assert (!prog_mode_o) else begin
        errors++;
        $display("Loader left idle on a byte other than the load command");
      end
    end
    send_byte(PROG_CMD);
    send_byte(count[7:0]);
    send_byte(count[15:8]);
    for (int w = 0; w < count; w++) begin
      for (int k = 0; k < 4; k++) begin
        send_byte(v_data[first + w][k*8 +: 8]);
      end
    end
  endtask

  task automatic wait_load_end();
    int n;
    n = 0;
    while (prog_mode_o && n < 200) begin
      @(negedge clk_i);
      n++;
    end
    assert (!prog_mode_o) else begin
      errors++;
      $display("Program mode stayed high after the last word");
    end
    assert (prog_seen) else begin
      errors++;
      $display("Program mode never rose during the load");
    end
    assert (sys_rst_n_o) else begin
      errors++;
      $display("Processor reset still asserted after the load");
    end
  endtask

  task automatic finish_run();
    $display("Checks done with %0d errors", errors);
    if (errors == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  endtask

  // Processor must be held in reset whenever the loader is active
  always @(negedge clk_i) begin
    if (rst_n && prog_mode_o) begin
      prog_seen = 1'b1;
      assert (!sys_rst_n_o) else begin
        errors++;
        $display("Processor reset released during a load");
      end
    end
  end

  initial begin : watchdog
    wait (limit_cycles > 0);
    repeat (limit_cycles) @(posedge clk_i);
    errors++;
    $display("Watchdog expired after %0d cycles, tests did not complete", limit_cycles);
    finish_run();
  end

  ////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////
  initial begin : main
    int          fd;
    int          i;
    int          n;
    int          bytes;
    int          waits;
    int          gnt_wait;
    int          spins;
    string       line;
    string       op;
    string       name;
    logic [31:0] a;
    logic [31:0] d;
    logic [31:0] e;
    logic [31:0] rdata;
    logic [31:0] t0;
    logic [3:0]  s;

    rst_n        = 1'b0;
    mem_valid_i  = 1'b0;
    mem_wstrb_i  = 4'h0;
    mem_addr_i   = 32'd0;
    mem_wdata_i  = 32'd0;
    prog_rx_i    = 1'b1;
    errors       = 0;
    limit_cycles = 0;
    lfsr         = 16'd57418;
    prog_seen    = 1'b0;

    fd = $fopen("verif/soc_mem_vectors.txt", "r");
    if (fd == 0) begin
      errors++;
      $display("Cannot open the vector file");
    end else begin
      while (!$feof(fd)) begin
        line = "";
        if ($fgets(line, fd) == 0) break;
        if (line.len() < 2 || line[0] == "#") continue;
        n = $sscanf(line, "%s %s %h %h %h %h", op, name, a, s, d, e);
        if (n == 6) begin
          v_op.push_back(op);
          v_name.push_back(name);
          v_addr.push_back(a);
          v_strb.push_back(s);
          v_data.push_back(d);
          v_exp.push_back(e);
        end
      end
      $fclose(fd);

      // Budget from UART traffic plus a fixed allowance per line
      bytes = 0;
      foreach (v_op[k]) begin
        if (v_op[k] == "P") bytes += 4 + 4 * v_data[k];
        if (v_op[k] == "S") bytes += 3 + 4 * v_data[k];
      end
      limit_cycles = bytes * 10 * CLKS_PER_BIT + 40 * (v_op.size() + 2);

      repeat (3) @(posedge clk_i);
      @(negedge clk_i);
      rst_n = 1'b1;
      @(negedge clk_i);
      assert (!mem_ready_o && !prog_mode_o && sys_rst_n_o) else begin
        errors++;
        $display("Outputs not at their reset values after reset");
      end

      i = 0;
      while (i < v_op.size()) begin
        idle_gap();
        case (v_op[i])
          "W": begin
            bus_access(v_addr[i], v_strb[i], v_data[i], rdata, waits, gnt_wait);
            check_latency(v_name[i], v_addr[i], waits);
            i++;
          end
          "R": begin
            bus_access(v_addr[i], 4'h0, 32'd0, rdata, waits, gnt_wait);
            check_latency(v_name[i], v_addr[i], waits);
            assert (rdata === v_exp[i]) else begin
              errors++;
              $display("Error %s: expected %h, actual %h", v_name[i], v_exp[i], rdata);
            end
            i++;
          end
          "T": begin
            bus_access(v_addr[i], 4'h0, 32'd0, t0, waits, gnt_wait);
            check_latency(v_name[i], v_addr[i], waits);
            idle_gap();
            bus_access(v_addr[i], 4'h0, 32'd0, rdata, waits, gnt_wait);
            assert (rdata > t0) else begin
              errors++;
              $display("Error %s: expected above %h, actual %h", v_name[i], t0, rdata);
            end
            i++;
          end
          "P": begin
            send_load(1'b1, v_addr[i][7:0], i + 1, v_data[i]);
            wait_load_end();
            i += 1 + v_data[i];
          end
          "S": begin
            fork
              send_load(1'b0, 8'h00, i + 1, v_data[i]);
              begin
                spins = 0;
                while (!dut0.ld_req && spins < 5000) begin
                  @(negedge clk_i);
                  spins++;
                end
                bus_access(v_addr[i], 4'h0, 32'd0, rdata, waits, gnt_wait);
                assert (gnt_wait > 0) else begin
                  errors++;
                  $display("CPU read was granted while the loader held the port");
                end
                assert (waits - gnt_wait == RAM_LATENCY + 1) else begin
                  errors++;
                  $display("Error %s latency: expected %0d, actual %0d", v_name[i],
                           RAM_LATENCY + 1, waits - gnt_wait);
                end
                assert (rdata === v_exp[i]) else begin
                  errors++;
                  $display("Error %s: expected %h, actual %h", v_name[i], v_exp[i], rdata);
                end
              end
            join
            wait_load_end();
            i += 1 + v_data[i];
          end
          default: begin
            errors++;
            $display("Vector line %0d has an operation that cannot stand alone", i);
            i++;
          end
        endcase
      end
    end
    finish_run();
  end

endmodule

`default_nettype wire

// File: verif/soc_mem_vectors.txt
# op name addr strb data expected, numbers in hex
# P and S give a word count in data and that many D lines follow, P sends addr[7:0] first
W wr_full     40000010 f 11223344 00000000
W wr_base     40000014 f a0b0c0d0 00000000
W wr_lane0    40000014 1 000000ee 00000000
W wr_lane23   40000014 c 12345678 00000000
R rd_full     40000010 0 00000000 11223344
R rd_merged   40000014 0 00000000 1234c0ee
W wr_fill     40000018 f ffffffff 00000000
W wr_lane1    40000018 2 00005a00 00000000
R rd_lane1    40000018 0 00000000 ffff5aff
T tmr_lo      30000000 0 00000000 00000000
R rd_tmr_hi   30000004 0 00000000 00000000
R rd_hole     50000010 0 00000000 00000000
W wr_hole     50000010 f deadbeef 00000000
R rd_no_alias 40000010 0 00000000 11223344
P load_a      0000003c 0 00000003 00000000
D word0       00000000 0 cafe0001 00000000
D word1       00000000 0 0badf00d 00000000
D word2       00000000 0 13572468 00000000
R rd_load0    40000000 0 00000000 cafe0001
R rd_load1    40000004 0 00000000 0badf00d
R rd_load2    40000008 0 00000000 13572468
R rd_keep     40000010 0 00000000 11223344
S stall_rd    40000014 0 00000002 1234c0ee
D word0b      00000000 0 89abcdef 00000000
D word1b      00000000 0 76543210 00000000
R rd_load0b   40000000 0 00000000 89abcdef
R rd_load1b   40000004 0 00000000 76543210
R rd_keep2    40000008 0 00000000 13572468

// File: verilog.f
logic/soc_mem_pkg.sv
logic/uart_prog_loader.sv
logic/ram_port_arbiter.sv
logic/byte_write_ram.sv
logic/iomem_decoder.sv
logic/soc_mem_top.sv
verif/soc_mem_asserts.sv
verif/soc_mem_tb.sv
